/* Makefile */
TOP := tb_mini_rv

simulate:
	verilator --binary --timing --assert --top-module $(TOP) -f mini_rv.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: simulate clean

/* dv/mini_rv_cases.txt */
# case <name> | p <instruction word, hex> from address 0 | run <free cycles, decimal>
# chk <register, decimal> <expected value, hex> | end closes the case
case alu_fwd
p 00500093
p 00708113
p 002081B3
p 40118233
p 0041C2B3
p 00126333
p 0022F3B3
p 00109433
p 12345537
p 001554B3
p 003225B3
p 0060A613
p 0F054693
p 00F6E713
p 7F077793
p 0000006F
run 40
chk 2 0000000C
chk 3 00000011
chk 4 0000000C
chk 5 0000001D
chk 6 0000000D
chk 7 0000000C
chk 8 000000A0
chk 9 0091A280
chk 10 12345000
chk 11 00000001
chk 12 00000001
chk 13 123450F0
chk 14 123450FF
chk 15 000000F0
end
case load_store
p 04000093
p 12300113
p 0020A023
p 45600193
p 0030A223
p 0000A203
p 004202B3
p 0040A303
p 404303B3
p 0070A423
p 0080A403
p 0000006F
run 30
chk 4 00000123
chk 5 00000246
chk 6 00000456
chk 7 00000333
chk 8 00000333
end
case branch
p 00300093
p 00300113
p 00400193
p 00000513
p 00000593
p 00000613
p 00000693
p 00208463
p 00100513
p 00309463
p 00100593
p 00308463
p 00100613
p 00209463
p 00100693
p 00D60733
p 0000006F
run 40
chk 10 00000000
chk 11 00000000
chk 12 00000001
chk 13 00000001
chk 14 00000002
end
case jal_link
p 01100093
p 00000313
p 00C002EF
p 02200093
p 03300313
p 001283B3
p 0000006F
run 20
chk 1 00000011
chk 5 0000000C
chk 6 00000000
chk 7 0000001D
end
case zero_debug
p 05500013
p ABCDE037
p 00700093
p FFF00113
p 0000006F
run 20
chk 0 00000000
chk 1 00000007
chk 2 FFFFFFFF
chk 1 00000007
chk 0 00000000
end

/* dv/mini_rv_checker.sv */
`timescale 1ns/10ps

module mini_rv_checker (
    input logic        clk,
    input logic        rst,
    input logic        debug,
    input logic [31:0] debug_data
);

    int   n_pass = 0;
    int   n_fail = 0;
    // debug_data nonzero while not selected
    int   n_idle_err = 0;

    logic edge_seen = 1'b0;
    logic debug_at_edge;
    logic rst_at_edge;

    // what the dut saw at the last rising edge
    always @(posedge clk) begin
        edge_seen     <= 1'b1;
        debug_at_edge <= debug;
        rst_at_edge   <= rst;
    end

    //////////////////////////////////////////////////
    // idle output watch
    //////////////////////////////////////////////////
    // registered output must be zero after reset or debug low
    always @(negedge clk) begin
        if (edge_seen && (rst_at_edge || !debug_at_edge) && debug_data !== 32'd0) begin
            n_idle_err++;
            $display("debug_data reads %h although debug was low", debug_data);
        end
    end

    //////////////////////////////////////////////////
    // register compare
    //////////////////////////////////////////////////
    // called with debug_addr just driven, result one edge later
    task automatic check_value(input string name, input logic [31:0] exp);
        @(posedge clk);
        // mid cycle, registered output settled
        @(negedge clk);
        if (debug_data === exp) begin
            n_pass++;
            $display("passed %s = %h", name, exp);
        end else begin
            n_fail++;
            $display("FAILED %s expected %h actual %h", name, exp, debug_data);
        end
    endtask

    // closing counts
    task automatic summary(output logic ok);
        $display("checks: %0d passed, %0d failed, %0d idle output errors",
                 n_pass, n_fail, n_idle_err);
        ok = (n_fail == 0) && (n_idle_err == 0) && (n_pass > 0);
    endtask

endmodule

/* dv/mini_rv_properties.sv */
`timescale 1ns/10ps

module mini_rv_properties (
    input logic        clk,
    input logic        rst,
    input logic        freeze,
    input logic [31:0] wb_reg,
    input logic        stall,
    input logic [31:0] if_id_pc,
    input logic [31:0] if_id_ins,
    input logic        debug,
    input logic [31:0] debug_data
);

    // number of failed assertions
    int n_err = 0;

    // register under writeback keeps its value across a frozen edge
    assert property (@(posedge clk) disable iff (rst) freeze |=> wb_reg === $past(wb_reg))
        else begin
            n_err++;
            $error("register file written while the pipeline is frozen");
        end

    // stalled instruction neither passed on nor flushed by a redirect
    assert property (@(posedge clk) disable iff (rst)
                     stall && !freeze |=> $stable(if_id_pc) && $stable(if_id_ins))
        else begin
            n_err++;
            $error("fetch-to-decode register changed while decode was stalled");
        end

    // output cleared one cycle after debug drops
    assert property (@(posedge clk) disable iff (rst) !debug |=> debug_data == 32'd0)
        else begin
            n_err++;
            $error("debug_data not zero one cycle after debug low");
        end

endmodule

bind mini_rv_core mini_rv_properties i_properties (
    .clk        (clk),
    .rst        (rst),
    .freeze     (bus.freeze),
    .wb_reg     (i_regfile.regs[bus.wb_rd]),
    .stall      (bus.stall),
    .if_id_pc   (bus.if_id_pc),
    .if_id_ins  (bus.if_id_ins),
    .debug      (debug),
    .debug_data (debug_data)
);

/* dv/tb_mini_rv.sv */
`timescale 1ns/10ps

module tb_mini_rv;

    localparam string case_file = "dv/mini_rv_cases.txt";

    logic        clk;
    logic        rst;
    logic        prog;
    logic        prog_we;
    logic [7:0]  prog_addr;
    logic [31:0] prog_data;
    logic        debug;
    logic [4:0]  debug_addr;
    logic [31:0] debug_data;

    // case table with one entry per case
    string       case_name [$];
    int          case_run [$];
    int          prog_first [$];
    int          prog_count [$];
    int          chk_first [$];
    int          chk_count [$];
    // flat program words and checks indexed from the table
    logic [31:0] prog_word [$];
    int          chk_reg [$];
    logic [31:0] chk_val [$];

    // watchdog budget in cycles stays zero until cases are known
    int          limit_cycles = 0;

    mini_rv_core i_mini_rv_core (
        .clk        (clk),
        .rst        (rst),
        .prog       (prog),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .debug      (debug),
        .debug_addr (debug_addr),
        .debug_data (debug_data)
    );

    mini_rv_checker i_checker (
        .clk        (clk),
        .rst        (rst),
        .debug      (debug),
        .debug_data (debug_data)
    );

    // 100 ns clock
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // inputs change 10 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    //////////////////////////////////////////////////
    // case file reader
    //////////////////////////////////////////////////
    task automatic load_cases(output logic ok);
        int          fd;
        int          n;
        int          num;
        logic [31:0] value;
        string       line;
        string       kw;
        string       arg;
        ok = 1'b0;
        fd = $fopen(case_file, "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                kw   = "";
                n    = $fgets(line, fd);
                n    = $sscanf(line, "%s", kw);
                // comment and blank lines fall through
                if (kw == "case") begin
                    n = $sscanf(line, "%s %s", kw, arg);
                    case_name.push_back(arg);
                    case_run.push_back(0);
                    prog_first.push_back(prog_word.size());
                    chk_first.push_back(chk_reg.size());
                end else if (kw == "p") begin
                    n = $sscanf(line, "%s %h", kw, value);
                    prog_word.push_back(value);
                end else if (kw == "run") begin
                    n = $sscanf(line, "%s %d", kw, num);
                    case_run[case_run.size() - 1] = num;
                end else if (kw == "chk") begin
                    n = $sscanf(line, "%s %d %h", kw, num, value);
                    chk_reg.push_back(num);
                    chk_val.push_back(value);
                end else if (kw == "end") begin
                    prog_count.push_back(prog_word.size() - prog_first[prog_first.size() - 1]);
                    chk_count.push_back(chk_reg.size() - chk_first[chk_first.size() - 1]);
                end
            end
            $fclose(fd);
            ok = (case_name.size() > 0) && (chk_count.size() == case_name.size());
        end
    endtask

    // program, reset, run and check cycles of all cases plus a margin
    function automatic int cycle_budget();
        int total;
        total = 2;
        foreach (case_name[i]) begin
            total += prog_count[i] + 2 + case_run[i] + 2 * chk_count[i] + 2;
        end
        return total + 100;
    endfunction

    //////////////////////////////////////////////////
    // one case is programmed, restarted, run and read back
    //////////////////////////////////////////////////
    task automatic run_case(input int idx);
        int    base;
        int    k;
        string name;
        base = prog_first[idx];
        prog = 1'b1;
        for (k = 0; k < prog_count[idx]; k++) begin
            prog_we   = 1'b1;
            prog_addr = 8'(k);
            prog_data = prog_word[base + k];
            next_cycle();
        end
        prog_we = 1'b0;
        // restart at pc 0 while still frozen
        rst = 1'b1;
        repeat (2) next_cycle();
        rst  = 1'b0;
        prog = 1'b0;
        repeat (case_run[idx]) next_cycle();
        // freeze and read registers one per cycle
        debug = 1'b1;
        base  = chk_first[idx];
        for (k = 0; k < chk_count[idx]; k++) begin
            debug_addr = 5'(chk_reg[base + k]);
            name = $sformatf("%s.x%0d", case_name[idx], chk_reg[base + k]);
            i_checker.check_value(name, chk_val[base + k]);
            next_cycle();
        end
        debug = 1'b0;
        next_cycle();
    endtask

    initial begin
        logic loaded;
        logic checks_ok;
        checks_ok  = 1'b0;
        rst        = 1'b1;
        prog       = 1'b0;
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        debug      = 1'b0;
        debug_addr = '0;
        load_cases(loaded);
        if (loaded) begin
            limit_cycles = cycle_budget();
            repeat (2) next_cycle();
            rst = 1'b0;
            foreach (case_name[i]) begin
                run_case(i);
            end
            i_checker.summary(checks_ok);
        end else begin
            $display("could not read any case from %s", case_file);
        end
        if (loaded && checks_ok && i_mini_rv_core.i_properties.n_err == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout after %0d cycles, the cases did not complete", limit_cycles);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* mini_rv.f */
rtl/mini_rv_pkg.sv
rtl/core_bus.sv
rtl/fetch.sv
rtl/regfile.sv
rtl/decode.sv
rtl/execute.sv
rtl/mem_wb.sv
rtl/mini_rv_core.sv
dv/mini_rv_checker.sv
dv/mini_rv_properties.sv
dv/tb_mini_rv.sv

/* rtl/core_bus.sv */
`timescale 1ns/10ps

interface core_bus
    import mini_rv_pkg::*;
(
    input logic clk,
    input logic rst
);

    // debug or prog, holds every stage
    logic freeze;

    // fetch to decode
    logic [31:0] if_id_pc;
    instr_t      if_id_ins;

    // decode control back to fetch
    logic        stall;
    logic        redirect;
    logic [31:0] redirect_pc;

    // register file read ports
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;

    // decode to execute
    logic [31:0] id_ex_pc;
    logic [31:0] id_ex_rs1_data;
    logic [31:0] id_ex_rs2_data;
    logic [31:0] id_ex_imm;
    logic [4:0]  id_ex_rs1;
    logic [4:0]  id_ex_rs2;
    logic [4:0]  id_ex_rd;
    alu_op_t     id_ex_alu_op;
    logic        id_ex_use_imm;
    logic        id_ex_mem_read;
    logic        id_ex_mem_write;
    logic        id_ex_reg_write;
    logic        id_ex_link;

    // execute to memory
    logic [31:0] ex_mem_alu_res;
    logic [31:0] ex_mem_store_data;
    logic [4:0]  ex_mem_rd;
    logic        ex_mem_mem_read;
    logic        ex_mem_mem_write;
    logic        ex_mem_reg_write;

    // memory to writeback
    logic [4:0]  wb_rd;
    logic        wb_we;
    logic [31:0] wb_res;

    //////////////////////////////////////////////////
    // one view per block
    //////////////////////////////////////////////////
    modport fetch (
        input  clk, rst, freeze, stall, redirect, redirect_pc,
        output if_id_pc, if_id_ins
    );

    modport regfile (
        input  clk, freeze, rs1_addr, rs2_addr, wb_rd, wb_we, wb_res,
        output rs1_data, rs2_data
    );

    // decode also sees ex_mem for branch forwarding and hazards
    modport decode (
        input  clk, rst, freeze, if_id_pc, if_id_ins, rs1_data, rs2_data,
        input  ex_mem_alu_res, ex_mem_rd, ex_mem_mem_read, ex_mem_reg_write,
        output stall, redirect, redirect_pc, rs1_addr, rs2_addr,
        output id_ex_pc, id_ex_rs1_data, id_ex_rs2_data, id_ex_imm,
        output id_ex_rs1, id_ex_rs2, id_ex_rd, id_ex_alu_op, id_ex_use_imm,
        output id_ex_mem_read, id_ex_mem_write, id_ex_reg_write, id_ex_link
    );

    modport execute (
        input  clk, rst, freeze,
        input  id_ex_pc, id_ex_rs1_data, id_ex_rs2_data, id_ex_imm,
        input  id_ex_rs1, id_ex_rs2, id_ex_rd, id_ex_alu_op, id_ex_use_imm,
        input  id_ex_mem_read, id_ex_mem_write, id_ex_reg_write, id_ex_link,
        input  wb_rd, wb_we, wb_res,
        output ex_mem_alu_res, ex_mem_store_data, ex_mem_rd,
        output ex_mem_mem_read, ex_mem_mem_write, ex_mem_reg_write
    );

    modport memwb (
        input  clk, rst, freeze,
        input  ex_mem_alu_res, ex_mem_store_data, ex_mem_rd,
        input  ex_mem_mem_read, ex_mem_mem_write, ex_mem_reg_write,
        output wb_rd, wb_we, wb_res
    );

endinterface

/* rtl/decode.sv */
`timescale 1ns/10ps

module decode
    import mini_rv_pkg::*;
(
    core_bus.decode bus
);

    instr_t      ins;
    logic [6:0]  opcode;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    // decoded control
    alu_op_t     alu_op;
    logic [31:0] imm;
    logic        use_imm;
    logic        mem_read;
    logic        mem_write;
    logic        wr_raw;
    logic        reg_write;
    logic        link;
    logic        is_branch;
    logic        is_jal;
    logic        uses_rs1;
    logic        uses_rs2;

    // branch compare and hazards
    logic [31:0] cmp_a;
    logic [31:0] cmp_b;
    logic        taken;
    logic        load_use;
    logic        branch_wait;

    //////////////////////////////////////////////////
    // field extraction through the format views
    //////////////////////////////////////////////////
    assign ins    = bus.if_id_ins;
    assign opcode = ins.r_fmt.opcode;
    assign rs1    = ins.r_fmt.rs1;
    assign rs2    = ins.r_fmt.rs2;
    assign rd     = ins.r_fmt.rd;

    assign imm_i = {{20{ins.i_fmt.imm12[11]}}, ins.i_fmt.imm12};
    assign imm_s = {{20{ins.s_fmt.imm7[6]}}, ins.s_fmt.imm7, ins.s_fmt.imm5};
    // b immediate rebuilt from the s view
    assign imm_b = {{20{ins.s_fmt.imm7[6]}}, ins.s_fmt.imm5[0], ins.s_fmt.imm7[5:0],
                    ins.s_fmt.imm5[4:1], 1'b0};
    assign imm_u = {ins.u_fmt.imm20, 12'd0};
    // j immediate rebuilt from the u view
    assign imm_j = {{12{ins.u_fmt.imm20[19]}}, ins.u_fmt.imm20[7:0], ins.u_fmt.imm20[8],
                    ins.u_fmt.imm20[18:9], 1'b0};

    assign bus.rs1_addr = rs1;
    assign bus.rs2_addr = rs2;

    // funct3 to alu op, shared by reg and imm forms
    function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic sub);
        alu_op_t op;
        case (f3)
            3'b000:  op = sub ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b100:  op = alu_xor;
            3'b101:  op = alu_srl;
            3'b110:  op = alu_or;
            3'b111:  op = alu_and;
            default: op = alu_add;
        endcase
        return op;
    endfunction

    always_comb begin
        alu_op    = alu_add;
        imm       = imm_i;
        use_imm   = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        wr_raw    = 1'b0;
        link      = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        case (opcode)
            op_reg: begin
                alu_op   = alu_sel(ins.r_fmt.funct3, ins.r_fmt.funct7[5]);
                wr_raw   = 1'b1;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            op_imm: begin
                alu_op   = alu_sel(ins.i_fmt.funct3, 1'b0);
                use_imm  = 1'b1;
                wr_raw   = 1'b1;
                uses_rs1 = 1'b1;
            end
            op_lui: begin
                alu_op  = alu_pass_b;
                imm     = imm_u;
                use_imm = 1'b1;
                wr_raw  = 1'b1;
            end
            op_load: begin
                use_imm  = 1'b1;
                mem_read = 1'b1;
                wr_raw   = 1'b1;
                uses_rs1 = 1'b1;
            end
            op_store: begin
                imm       = imm_s;
                use_imm   = 1'b1;
                mem_write = 1'b1;
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
            end
            op_branch: begin
                imm       = imm_b;
                is_branch = 1'b1;
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
            end
            op_jal: begin
                // execute swaps in pc + 4
                alu_op = alu_pass_b;
                imm    = imm_j;
                wr_raw = 1'b1;
                link   = 1'b1;
                is_jal = 1'b1;
            end
            default: begin
                alu_op = alu_add;
            end
        endcase
    end

    // writes to x0 dropped here, so later stages never see them
    assign reg_write = wr_raw && (rd != 5'd0);

    //////////////////////////////////////////////////
    // branch resolution
    //////////////////////////////////////////////////
    // ex_mem alu result forwarded, writeback comes via regfile bypass
    always_comb begin
        cmp_a = bus.rs1_data;
        cmp_b = bus.rs2_data;
        if (bus.ex_mem_reg_write && !bus.ex_mem_mem_read && bus.ex_mem_rd == rs1) begin
            cmp_a = bus.ex_mem_alu_res;
        end
        if (bus.ex_mem_reg_write && !bus.ex_mem_mem_read && bus.ex_mem_rd == rs2) begin
            cmp_b = bus.ex_mem_alu_res;
        end
    end

    // funct3 bit 0 picks bne over beq
    assign taken = ins.s_fmt.funct3[0] ? (cmp_a != cmp_b) : (cmp_a == cmp_b);

    // load result not ready for the next instruction
    assign load_use = bus.id_ex_mem_read && bus.id_ex_reg_write &&
                      ((uses_rs1 && bus.id_ex_rd == rs1) ||
                       (uses_rs2 && bus.id_ex_rd == rs2));

    // compare waits on results still in execute or a load in memory
    assign branch_wait = is_branch &&
                         ((bus.id_ex_reg_write &&
                           (bus.id_ex_rd == rs1 || bus.id_ex_rd == rs2)) ||
                          (bus.ex_mem_reg_write && bus.ex_mem_mem_read &&
                           (bus.ex_mem_rd == rs1 || bus.ex_mem_rd == rs2)));

    assign bus.stall       = load_use || branch_wait;
    // stall wins over redirect
    assign bus.redirect    = !bus.stall && (is_jal || (is_branch && taken));
    assign bus.redirect_pc = bus.if_id_pc + (is_jal ? imm_j : imm_b);

    //////////////////////////////////////////////////
    // decode-to-execute register
    //////////////////////////////////////////////////
    // control, bubble on stall
    always_ff @(posedge bus.clk) begin
        if (bus.rst) begin
            bus.id_ex_mem_read  <= 1'b0;
            bus.id_ex_mem_write <= 1'b0;
            bus.id_ex_reg_write <= 1'b0;
            bus.id_ex_link      <= 1'b0;
        end else if (!bus.freeze) begin
            bus.id_ex_mem_read  <= mem_read && !bus.stall;
            bus.id_ex_mem_write <= mem_write && !bus.stall;
            bus.id_ex_reg_write <= reg_write && !bus.stall;
            bus.id_ex_link      <= link && !bus.stall;
        end
    end

    // payload
    always_ff @(posedge bus.clk) begin
        if (!bus.freeze) begin
            bus.id_ex_pc       <= bus.if_id_pc;
            bus.id_ex_rs1_data <= bus.rs1_data;
            bus.id_ex_rs2_data <= bus.rs2_data;
            bus.id_ex_imm      <= imm;
            bus.id_ex_rs1      <= rs1;
            bus.id_ex_rs2      <= rs2;
            bus.id_ex_rd       <= rd;
            bus.id_ex_alu_op   <= alu_op;
            bus.id_ex_use_imm  <= use_imm;
        end
    end

endmodule

/* rtl/execute.sv */
`timescale 1ns/10ps

module execute
    import mini_rv_pkg::*;
(
    core_bus.execute bus
);

    logic [31:0] op_a;
    logic [31:0] rs2_fwd;
    logic [31:0] op_b;
    logic [31:0] alu_out;
    logic [31:0] result;

    // newest producer first, ex_mem then writeback
    function automatic logic [31:0] fwd(input logic [4:0] r, input logic [31:0] reg_val);
        logic [31:0] val;
        if (r != 5'd0 && bus.ex_mem_reg_write && bus.ex_mem_rd == r) begin
            val = bus.ex_mem_alu_res;
        end else if (r != 5'd0 && bus.wb_we && bus.wb_rd == r) begin
            val = bus.wb_res;
        end else begin
            val = reg_val;
        end
        return val;
    endfunction

    assign op_a    = fwd(bus.id_ex_rs1, bus.id_ex_rs1_data);
    assign rs2_fwd = fwd(bus.id_ex_rs2, bus.id_ex_rs2_data);
    assign op_b    = bus.id_ex_use_imm ? bus.id_ex_imm : rs2_fwd;

    //////////////////////////////////////////////////
    // alu
    //////////////////////////////////////////////////
    always_comb begin
        case (bus.id_ex_alu_op)
            alu_add:    alu_out = op_a + op_b;
            alu_sub:    alu_out = op_a - op_b;
            alu_and:    alu_out = op_a & op_b;
            alu_or:     alu_out = op_a | op_b;
            alu_xor:    alu_out = op_a ^ op_b;
            alu_slt:    alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
            alu_sll:    alu_out = op_a << op_b[4:0];
            alu_srl:    alu_out = op_a >> op_b[4:0];
            alu_pass_b: alu_out = op_b;
            default:    alu_out = op_a + op_b;
        endcase
    end

    // jal writes its return address
    assign result = bus.id_ex_link ? bus.id_ex_pc + 32'd4 : alu_out;

    //////////////////////////////////////////////////
    // execute-to-memory register
    //////////////////////////////////////////////////
    always_ff @(posedge bus.clk) begin
        if (bus.rst) begin
            bus.ex_mem_mem_read  <= 1'b0;
            bus.ex_mem_mem_write <= 1'b0;
            bus.ex_mem_reg_write <= 1'b0;
        end else if (!bus.freeze) begin
            bus.ex_mem_mem_read  <= bus.id_ex_mem_read;
            bus.ex_mem_mem_write <= bus.id_ex_mem_write;
            bus.ex_mem_reg_write <= bus.id_ex_reg_write;
        end
    end

    always_ff @(posedge bus.clk) begin
        if (!bus.freeze) begin
            bus.ex_mem_alu_res    <= result;
            // store data must see forwarded rs2
            bus.ex_mem_store_data <= rs2_fwd;
            bus.ex_mem_rd         <= bus.id_ex_rd;
        end
    end

endmodule

/* rtl/fetch.sv */
`timescale 1ns/10ps

module fetch
    import mini_rv_pkg::*;
#(
    parameter int imem_words = imem_words_def
) (
    core_bus.fetch bus,
    input  logic        prog_we,
    input  logic [7:0]  prog_addr,
    input  logic [31:0] prog_data
);

    localparam int aw = $clog2(imem_words);

    logic [31:0] imem [imem_words];
    logic [31:0] pc;

    // program port, one word per strobe
    always_ff @(posedge bus.clk) begin
        if (prog_we) begin
            imem[prog_addr[aw-1:0]] <= prog_data;
        end
    end

    // pc and fetch-to-decode register
    always_ff @(posedge bus.clk) begin
        if (bus.rst) begin
            pc            <= '0;
            bus.if_id_pc  <= '0;
            bus.if_id_ins <= nop_word;
        end else if (bus.freeze || bus.stall) begin
            // hold pc and if_id
            pc <= pc;
        end else if (bus.redirect) begin
            // drop the word fetched behind the branch
            pc            <= bus.redirect_pc;
            bus.if_id_ins <= nop_word;
        end else begin
            pc            <= pc + 32'd4;
            bus.if_id_pc  <= pc;
            bus.if_id_ins <= imem[pc[aw+1:2]];
        end
    end

endmodule

/* rtl/mem_wb.sv */
`timescale 1ns/10ps

module mem_wb
    import mini_rv_pkg::*;
#(
    parameter int dmem_words = dmem_words_def
) (
    core_bus.memwb bus
);

    localparam int aw = $clog2(dmem_words);

    logic [31:0]   dmem [dmem_words];
    logic [aw-1:0] word_addr;
    logic [31:0]   load_data;

    // word index, byte offset bits ignored
    assign word_addr = bus.ex_mem_alu_res[aw+1:2];
    assign load_data = dmem[word_addr];

    // sw only, held off while frozen
    always_ff @(posedge bus.clk) begin
        if (bus.ex_mem_mem_write && !bus.freeze) begin
            dmem[word_addr] <= bus.ex_mem_store_data;
        end
    end

    //////////////////////////////////////////////////
    // memory-to-writeback register
    //////////////////////////////////////////////////
    always_ff @(posedge bus.clk) begin
        if (bus.rst) begin
            bus.wb_we <= 1'b0;
        end else if (!bus.freeze) begin
            bus.wb_we <= bus.ex_mem_reg_write;
        end
    end

    always_ff @(posedge bus.clk) begin
        if (!bus.freeze) begin
            bus.wb_rd  <= bus.ex_mem_rd;
            // lw data or alu result
            bus.wb_res <= bus.ex_mem_mem_read ? load_data : bus.ex_mem_alu_res;
        end
    end

endmodule

/* rtl/mini_rv_core.sv */
`timescale 1ns/10ps

module mini_rv_core
    import mini_rv_pkg::*;
#(
    parameter int imem_words = imem_words_def,
    parameter int dmem_words = dmem_words_def
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        prog,
    input  logic        prog_we,
    input  logic [7:0]  prog_addr,
    input  logic [31:0] prog_data,
    input  logic        debug,
    input  logic [4:0]  debug_addr,
    output logic [31:0] debug_data
);

    logic [31:0] debug_rd;

    core_bus bus (
        .clk (clk),
        .rst (rst)
    );

    // pipeline holds while programming or inspecting
    assign bus.freeze = debug || prog;

    //////////////////////////////////////////////////
    // pipeline blocks
    //////////////////////////////////////////////////
    fetch #(
        .imem_words (imem_words)
    ) i_fetch (
        .bus       (bus.fetch),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data)
    );

    regfile i_regfile (
        .bus        (bus.regfile),
        .debug_addr (debug_addr),
        .debug_rd   (debug_rd)
    );

    decode i_decode (
        .bus (bus.decode)
    );

    execute i_execute (
        .bus (bus.execute)
    );

    mem_wb #(
        .dmem_words (dmem_words)
    ) i_mem_wb (
        .bus (bus.memwb)
    );

    // registered debug view, zero when not selected
    always_ff @(posedge clk) begin
        if (rst) begin
            debug_data <= '0;
        end else if (debug) begin
            debug_data <= debug_rd;
        end else begin
            debug_data <= '0;
        end
    end

endmodule

/* rtl/mini_rv_pkg.sv */
package mini_rv_pkg;

    //////////////////////////////////////////////////
    // base opcodes of the supported RV32I subset
    //////////////////////////////////////////////////
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;

    // addi x0, x0, 0 used as pipeline bubble
    localparam logic [31:0] nop_word = 32'h0000_0013;

    // default memory depths in words
    localparam int imem_words_def = 256;
    localparam int dmem_words_def = 256;

    // alu operations, pass_b feeds lui and the jal link
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_pass_b
    } alu_op_t;

    //////////////////////////////////////////////////
    // instruction word, one view per encoding format
    //////////////////////////////////////////////////
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // b format shares this layout
    typedef struct packed {
        logic [6:0] imm7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm5;
        logic [6:0] opcode;
    } s_fmt_t;

    // j format shares this layout
    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        u_fmt_t u_fmt;
    } instr_t;

endpackage

/* rtl/regfile.sv */
`timescale 1ns/10ps

module regfile (
    core_bus.regfile    bus,
    input  logic [4:0]  debug_addr,
    output logic [31:0] debug_rd
);

    logic [31:0] regs [32];
    logic        wr_en;

    // x0 never written, nothing committed while frozen
    assign wr_en = bus.wb_we && !bus.freeze && (bus.wb_rd != 5'd0);

    always_ff @(posedge bus.clk) begin
        if (wr_en) begin
            regs[bus.wb_rd] <= bus.wb_res;
        end
    end

    // read with bypass of the word being written this cycle
    function automatic logic [31:0] rd_port(input logic [4:0] addr);
        logic [31:0] val;
        if (addr == 5'd0) begin
            val = '0;
        end else if (bus.wb_we && bus.wb_rd == addr) begin
            val = bus.wb_res;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    assign bus.rs1_data = rd_port(bus.rs1_addr);
    assign bus.rs2_data = rd_port(bus.rs2_addr);
    // third port for the debug output
    assign debug_rd     = rd_port(debug_addr);

endmodule
